/* vlog.f */
+incdir+.
spm_pkg.sv
spm_bank.sv
spm_bankgroup.sv
spm_config_seq.sv
scratchpad.sv
tb_scratchpad.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the scratchpad testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_scratchpad \
	-f vlog.f \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see sim.log"
exit 1

/* spm_tb_model.svh */
`ifndef SPM_TB_MODEL_SVH
`define SPM_TB_MODEL_SVH

// mirror of the config buffer and the active word
spm_cfg_word_t m_cfg_buf [SPM_CFG_DEPTH];
int            m_init_cnt;
int            m_run_ptr;
spm_cfg_word_t m_active;

// physical image, group x bank x row
logic [SPM_D_W-1:0] m_mem [SPM_NUM_BG][SPM_NUM_BANKS][SPM_BANK_DEPTH];
bit                 m_written [SPM_NUM_BG][SPM_NUM_BANKS][SPM_BANK_DEPTH];

// response due on the port one cycle later
spm_rsp_t exp_rsp [SPM_NUM_BG];
bit       exp_known [SPM_NUM_BG];

// interleaved takes the low two address bits, blocked the high two
function automatic int phys_bank(input logic [SPM_A_W-1:0] addr, input spm_pattern_e pat);
	if (pat == PAT_BLOCKED) begin
		return int'(addr[9:8]);
	end
	return int'(addr[1:0]);
endfunction

function automatic int phys_row(input logic [SPM_A_W-1:0] addr, input spm_pattern_e pat);
	if (pat == PAT_BLOCKED) begin
		return int'(addr[7:0]);
	end
	return int'(addr[9:2]);
endfunction

// memory image survives reset
task automatic model_reset();
	m_init_cnt = 0;
	m_run_ptr = 0;
	m_active = '0;
	for (int g = 0; g < SPM_NUM_BG; g++) begin
		exp_rsp[g] = '0;
		exp_known[g] = 1'b0;
	end
endtask

// one clock edge with the given inputs
task automatic model_step(input logic init, input logic run, input spm_cfg_word_t word,
	input spm_req_t ex, input spm_req_t [SPM_NUM_BG-1:0] sw);
	spm_req_t req;
	int b;
	int r;
	for (int g = 0; g < SPM_NUM_BG; g++) begin
		req = m_active[g].sel ? sw[g] : ex;
		b = phys_bank(req.addr, m_active[g].pattern);
		r = phys_row(req.addr, m_active[g].pattern);
		exp_rsp[g] = '0;
		exp_known[g] = 1'b0;
		if (m_active[g].en && req.ren && !req.wen) begin
			exp_rsp[g].valid = 1'b1;
			exp_rsp[g].lane = m_active[g].lane;
			exp_rsp[g].data = m_mem[g][b][r];
			exp_known[g] = m_written[g][b][r];
		end
		if (m_active[g].en && req.wen) begin
			m_mem[g][b][r] = req.data;
			m_written[g][b][r] = 1'b1;
		end
	end
	if (init) begin
		if (m_init_cnt < SPM_CFG_DEPTH) begin
			m_cfg_buf[m_init_cnt] = word;
			m_init_cnt++;
		end
	end else if (run && m_init_cnt != 0) begin
		m_active = m_cfg_buf[m_run_ptr];
		m_run_ptr = (m_run_ptr + 1 == m_init_cnt) ? 0 : m_run_ptr + 1;
	end
endtask

`endif

/* tb_scratchpad.sv */
`timescale 1ns/1ps

module tb_scratchpad;
	import spm_pkg::*;

	`include "spm_tb_model.svh"

	// upper bounds of each phase in cycles
	localparam int PH1_CYC = 30;
	localparam int PH2_CYC = 50;
	localparam int PH3_CYC = 215;
	localparam int PH4_CYC = 215;
	localparam int PH5_CYC = 530;
	localparam int PH6_CYC = 275;
	localparam int PH_SUM = PH1_CYC + PH2_CYC + PH3_CYC + PH4_CYC + PH5_CYC + PH6_CYC;
	localparam int CYCLE_LIMIT = PH_SUM * 6 / 5;

	logic                         clk = 1'b0;
	logic                         rst;
	logic                         init;
	logic                         run;
	spm_cfg_word_t                cfg_word;
	spm_req_t                     ex_req;
	spm_req_t [SPM_NUM_BG-1:0]    sw_req;
	spm_rsp_t [SPM_NUM_BG-1:0]    sw_rsp;
	spm_rsp_t [SPM_NUM_BG-1:0]    last_rsp;

	// values applied at the next falling edge
	logic                         rst_nxt;
	logic                         init_nxt;
	logic                         run_nxt;
	spm_cfg_word_t                cfg_nxt;
	spm_req_t                     ex_nxt;
	spm_req_t [SPM_NUM_BG-1:0]    sw_nxt;

	integer      seed = 71169;
	logic [31:0] rnd;
	int          rsp_errs = 0;
	int          cfg_errs = 0;
	int          cycle_cnt = 0;

	scratchpad scratchpad_i (
		.clk        (clk),
		.rst        (rst),
		.cfg_word_i (cfg_word),
		.init_i     (init),
		.run_i      (run),
		.ex_req_i   (ex_req),
		.sw_req_i   (sw_req),
		.sw_rsp_o   (sw_rsp)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic check_rsp(input string name, input spm_rsp_t exp, input spm_rsp_t act,
		input bit data_known);
		if (act.valid !== exp.valid || (exp.valid && act.lane !== exp.lane) ||
			(exp.valid && data_known && act.data !== exp.data)) begin
			rsp_errs++;
			$display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	task automatic check_cfg(input string name, input spm_cfg_word_t exp,
		input spm_cfg_word_t act);
		if (act !== exp) begin
			cfg_errs++;
			$display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	// check the outputs, apply staged inputs, advance the model
	task automatic step_cycle();
		@(negedge clk);
		for (int g = 0; g < SPM_NUM_BG; g++) begin
			check_rsp($sformatf("sw_rsp_o[%0d]", g), exp_rsp[g], sw_rsp[g], exp_known[g]);
		end
		last_rsp = sw_rsp;
		rst = rst_nxt;
		init = init_nxt;
		run = run_nxt;
		cfg_word = cfg_nxt;
		ex_req = ex_nxt;
		sw_req = sw_nxt;
		if (rst_nxt) begin
			model_reset();
		end else begin
			model_step(init_nxt, run_nxt, cfg_nxt, ex_nxt, sw_nxt);
		end
		init_nxt = 1'b0;
		run_nxt = 1'b0;
		cfg_nxt = '0;
		ex_nxt = '0;
		sw_nxt = '0;
	endtask

	task automatic do_reset();
		rst_nxt = 1'b1;
		repeat (8) step_cycle();
		rst_nxt = 1'b0;
	endtask

	task automatic load_cfg(input spm_cfg_word_t word);
		cfg_nxt = word;
		init_nxt = 1'b1;
		step_cycle();
	endtask

	task automatic run_pulse();
		run_nxt = 1'b1;
		step_cycle();
	endtask

	// 64 addresses that reach every bank under both patterns
	function automatic logic [SPM_A_W-1:0] pool_addr(input int i);
		logic [5:0] b;
		b = 6'(i);
		return {b[5:4], 4'b0000, b[3:2], b[1:0]};
	endfunction

	function automatic spm_req_t rand_req();
		spm_req_t q;
		logic [31:0] r;
		r = $random(seed);
		q.wen = r[0];
		q.ren = r[1];
		q.addr = pool_addr(int'(r[7:2]));
		q.data = $random(seed);
		return q;
	endfunction

	function automatic spm_cfg_word_t uniform_cfg(input logic en, input logic sel,
		input spm_pattern_e pat);
		spm_cfg_word_t w;
		logic [31:0] r;
		r = $random(seed);
		for (int g = 0; g < SPM_NUM_BG; g++) begin
			w[g].en = en;
			w[g].sel = sel;
			w[g].pattern = pat;
			w[g].lane = r[g*2 +: 2];
		end
		return w;
	endfunction

	task automatic random_traffic(input int n);
		repeat (n) begin
			ex_nxt = rand_req();
			for (int g = 0; g < SPM_NUM_BG; g++) begin
				sw_nxt[g] = rand_req();
			end
			step_cycle();
		end
	endtask

	// external bus pass over the pool or over addresses 0 up
	task automatic addr_pass(input bit write, input int count, input bit pooled);
		for (int i = 0; i < count; i++) begin
			ex_nxt.wen = write;
			ex_nxt.ren = !write;
			ex_nxt.addr = pooled ? pool_addr(i) : SPM_A_W'(i);
			ex_nxt.data = $random(seed);
			step_cycle();
		end
	endtask

	// run pulse, then one read on every port shows lane and enable
	task automatic probe_config();
		spm_cfg_word_t want;
		spm_cfg_word_t seen;
		logic [SPM_A_W-1:0] a;
		run_pulse();
		a = pool_addr(int'($random(seed) & 63));
		ex_nxt.ren = 1'b1;
		ex_nxt.addr = a;
		for (int g = 0; g < SPM_NUM_BG; g++) begin
			sw_nxt[g].ren = 1'b1;
			sw_nxt[g].addr = a;
		end
		step_cycle();
		want = m_active;
		step_cycle();
		seen = want;
		for (int g = 0; g < SPM_NUM_BG; g++) begin
			seen[g].en = last_rsp[g].valid;
			if (last_rsp[g].valid) begin
				seen[g].lane = last_rsp[g].lane;
			end
		end
		check_cfg("cfg_active", want, seen);
	endtask

	initial begin
		spm_cfg_word_t base;
		spm_cfg_word_t off;
		rst = 1'b1;
		init = 1'b0;
		run = 1'b0;
		cfg_word = '0;
		ex_req = '0;
		sw_req = '0;
		rst_nxt = 1'b1;
		init_nxt = 1'b0;
		run_nxt = 1'b0;
		cfg_nxt = '0;
		ex_nxt = '0;
		sw_nxt = '0;
		model_reset();

		// reset, then traffic while every group is disabled
		do_reset();
		run_pulse();
		random_traffic(16);
		step_cycle();

		// five random words that run wraps through
		do_reset();
		repeat (5) begin
			rnd = $random(seed);
			load_cfg(spm_cfg_word_t'(rnd[19:0]));
		end
		repeat (12) probe_config();

		// external bus source
		do_reset();
		rnd = $random(seed);
		load_cfg(uniform_cfg(1'b1, 1'b0, spm_pattern_e'(rnd[0])));
		run_pulse();
		random_traffic(200);
		step_cycle();

		// switch source
		do_reset();
		rnd = $random(seed);
		load_cfg(uniform_cfg(1'b1, 1'b1, spm_pattern_e'(rnd[0])));
		run_pulse();
		random_traffic(200);
		step_cycle();

		// write interleaved and read back blocked
		do_reset();
		load_cfg(uniform_cfg(1'b1, 1'b0, PAT_INTERLEAVE));
		load_cfg(uniform_cfg(1'b1, 1'b0, PAT_BLOCKED));
		run_pulse();
		addr_pass(1'b1, 256, 1'b0);
		run_pulse();
		addr_pass(1'b0, 256, 1'b0);
		step_cycle();

		// groups 0 and 2 switched off for a write pass
		do_reset();
		base = uniform_cfg(1'b1, 1'b0, PAT_INTERLEAVE);
		off = base;
		off[0].en = 1'b0;
		off[2].en = 1'b0;
		load_cfg(base);
		load_cfg(off);
		load_cfg(base);
		run_pulse();
		addr_pass(1'b1, 64, 1'b1);
		run_pulse();
		addr_pass(1'b1, 64, 1'b1);
		addr_pass(1'b0, 64, 1'b1);
		run_pulse();
		addr_pass(1'b0, 64, 1'b1);
		step_cycle();

		$display("response errors: %0d, config errors: %0d", rsp_errs, cfg_errs);
		if (rsp_errs == 0 && cfg_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* scratchpad.sv */
`timescale 1ns/1ps

module scratchpad (
	input  logic                                          clk,
	input  logic                                          rst,
	input  spm_pkg::spm_cfg_word_t                        cfg_word_i,
	input  logic                                          init_i,
	input  logic                                          run_i,
	input  spm_pkg::spm_req_t                             ex_req_i,
	input  spm_pkg::spm_req_t [spm_pkg::SPM_NUM_BG-1:0]   sw_req_i,
	output spm_pkg::spm_rsp_t [spm_pkg::SPM_NUM_BG-1:0]   sw_rsp_o
);
	import spm_pkg::*;

	// active configuration, applies from the edge after a run pulse
	spm_cfg_word_t cfg_active;

	spm_config_seq u_config_seq (
		.clk        (clk),
		.rst        (rst),
		.init_i     (init_i),
		.run_i      (run_i),
		.cfg_word_i (cfg_word_i),
		.cfg_o      (cfg_active)
	);

	// every group sees the external bus, plus its own switch input
	for (genvar g = 0; g < SPM_NUM_BG; g++) begin : g_bg
		spm_bankgroup u_bankgroup (
			.clk      (clk),
			.rst      (rst),
			.cfg_i    (cfg_active[g]),
			.ex_req_i (ex_req_i),
			.sw_req_i (sw_req_i[g]),
			.rsp_o    (sw_rsp_o[g])
		);
	end

endmodule

/* spm_config_seq.sv */
`timescale 1ns/1ps

module spm_config_seq (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   init_i,
	input  logic                   run_i,
	input  spm_pkg::spm_cfg_word_t cfg_word_i,
	output spm_pkg::spm_cfg_word_t cfg_o
);
	import spm_pkg::*;

	spm_cfg_word_t            cfg_buf [SPM_CFG_DEPTH];
	logic [SPM_CFG_CNT_W-1:0] init_cnt;
	logic [SPM_CFG_PTR_W-1:0] run_ptr;
	logic [SPM_CFG_CNT_W-1:0] run_inc;
	logic                     buf_full;
	logic                     do_init;
	logic                     do_run;

	// init_cnt doubles as the init pointer and the number of loaded words
	assign buf_full = (init_cnt == SPM_CFG_CNT_W'(SPM_CFG_DEPTH));
	assign do_init = init_i & ~buf_full;
	assign do_run = run_i & ~init_i & (init_cnt != '0);
	assign run_inc = SPM_CFG_CNT_W'(run_ptr) + 1'b1;

	always_ff @(posedge clk) begin
		if (do_init) begin
			cfg_buf[init_cnt[SPM_CFG_PTR_W-1:0]] <= cfg_word_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			init_cnt <= '0;
			run_ptr <= '0;
			cfg_o <= '0;
		end else if (do_init) begin
			init_cnt <= init_cnt + 1'b1;
		end else if (do_run) begin
			cfg_o <= cfg_buf[run_ptr];
			// wrap after the last loaded word
			if (run_inc == init_cnt) begin
				run_ptr <= '0;
			end else begin
				run_ptr <= run_inc[SPM_CFG_PTR_W-1:0];
			end
		end
	end

	a_run_ptr_in_range : assert property (
		@(posedge clk) disable iff (rst)
		(init_cnt != '0) |-> (SPM_CFG_CNT_W'(run_ptr) < init_cnt)
	);

endmodule

/* spm_bankgroup.sv */
`timescale 1ns/1ps

module spm_bankgroup (
	input  logic                 clk,
	input  logic                 rst,
	input  spm_pkg::spm_bg_cfg_t cfg_i,
	input  spm_pkg::spm_req_t    ex_req_i,
	input  spm_pkg::spm_req_t    sw_req_i,
	output spm_pkg::spm_rsp_t    rsp_o
);
	import spm_pkg::*;

	spm_req_t                  req;
	logic [SPM_BANK_IDX_W-1:0] bank_sel;
	logic [SPM_ROW_W-1:0]      row;
	logic                      wr_en;
	logic                      rd_en;
	logic [SPM_NUM_BANKS-1:0]  bank_we;
	logic [SPM_NUM_BANKS-1:0]  bank_re;
	logic [SPM_D_W-1:0]        bank_dout [SPM_NUM_BANKS];

	logic                      rd_vld_q;
	logic [SPM_BANK_IDX_W-1:0] bank_q;
	logic [SPM_LANE_W-1:0]     lane_q;

	// sel high takes the group's own switch input
	assign req = cfg_i.sel ? sw_req_i : ex_req_i;

	assign bank_sel = spm_bank_of(req.addr, cfg_i.pattern);
	assign row = spm_row_of(req.addr, cfg_i.pattern);

	// a write wins over a read in the same request
	assign wr_en = cfg_i.en & req.wen;
	assign rd_en = cfg_i.en & req.ren & ~req.wen;

	always_comb begin
		bank_we = '0;
		bank_re = '0;
		bank_we[bank_sel] = wr_en;
		bank_re[bank_sel] = rd_en;
	end

	for (genvar b = 0; b < SPM_NUM_BANKS; b++) begin : g_bank
		spm_bank u_bank (
			.clk    (clk),
			.rst    (rst),
			.we_i   (bank_we[b]),
			.re_i   (bank_re[b]),
			.row_i  (row),
			.din_i  (req.data),
			.dout_o (bank_dout[b])
		);
	end

	// lane is sampled with the request rather than with the data
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_vld_q <= 1'b0;
			bank_q <= '0;
			lane_q <= '0;
		end else begin
			rd_vld_q <= rd_en;
			if (rd_en) begin
				bank_q <= bank_sel;
				lane_q <= cfg_i.lane;
			end
		end
	end

	// idle port drives zeros
	always_comb begin
		rsp_o = '0;
		if (rd_vld_q) begin
			rsp_o.valid = 1'b1;
			rsp_o.lane = lane_q;
			rsp_o.data = bank_dout[bank_q];
		end
	end

	// no read strobe on the selected source port means no valid next cycle
	a_no_spurious_valid : assert property (
		@(posedge clk) disable iff (rst)
		!(cfg_i.en && (cfg_i.sel ? sw_req_i.ren : ex_req_i.ren)) |=> !rsp_o.valid
	);

endmodule

/* spm_bank.sv */
`timescale 1ns/1ps

module spm_bank (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         we_i,
	input  logic                         re_i,
	input  logic [spm_pkg::SPM_ROW_W-1:0] row_i,
	input  logic [spm_pkg::SPM_D_W-1:0]   din_i,
	output logic [spm_pkg::SPM_D_W-1:0]   dout_o
);
	import spm_pkg::*;

	logic [SPM_D_W-1:0] mem [SPM_BANK_DEPTH];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[row_i] <= din_i;
		end
	end

	// output register holds the last word read
	always_ff @(posedge clk) begin
		if (rst) begin
			dout_o <= '0;
		end else if (re_i) begin
			dout_o <= mem[row_i];
		end
	end

endmodule

/* spm_pkg.sv */
package spm_pkg;

	// group address, data and lane widths
	localparam int unsigned SPM_A_W = 10;
	localparam int unsigned SPM_D_W = 32;
	localparam int unsigned SPM_LANE_W = 2;

	localparam int unsigned SPM_NUM_BG = 4;
	localparam int unsigned SPM_NUM_BANKS = 4;
	localparam int unsigned SPM_BANK_DEPTH = 256;
	localparam int unsigned SPM_BANK_IDX_W = $clog2(SPM_NUM_BANKS);
	localparam int unsigned SPM_ROW_W = $clog2(SPM_BANK_DEPTH);

	// config buffer, the count needs one bit more than the pointer
	localparam int unsigned SPM_CFG_DEPTH = 8;
	localparam int unsigned SPM_CFG_PTR_W = $clog2(SPM_CFG_DEPTH);
	localparam int unsigned SPM_CFG_CNT_W = SPM_CFG_PTR_W + 1;

	typedef enum logic {
		PAT_INTERLEAVE = 1'b0,
		PAT_BLOCKED    = 1'b1
	} spm_pattern_e;

	// same layout on the external bus and on each switch input
	typedef struct packed {
		logic               wen;
		logic               ren;
		logic [SPM_A_W-1:0] addr;
		logic [SPM_D_W-1:0] data;
	} spm_req_t;

	typedef struct packed {
		logic                  en;
		logic                  sel;
		spm_pattern_e          pattern;
		logic [SPM_LANE_W-1:0] lane;
	} spm_bg_cfg_t;

	// group 0 sits in the lowest element
	typedef spm_bg_cfg_t [SPM_NUM_BG-1:0] spm_cfg_word_t;

	typedef struct packed {
		logic                  valid;
		logic [SPM_LANE_W-1:0] lane;
		logic [SPM_D_W-1:0]    data;
	} spm_rsp_t;

	// bank index of a group address
	function automatic logic [SPM_BANK_IDX_W-1:0] spm_bank_of(
		input logic [SPM_A_W-1:0] addr,
		input spm_pattern_e       pattern
	);
		logic [SPM_BANK_IDX_W-1:0] idx;
		if (pattern == PAT_BLOCKED) begin
			idx = addr[SPM_A_W-1 -: SPM_BANK_IDX_W];
		end else begin
			idx = addr[SPM_BANK_IDX_W-1:0];
		end
		return idx;
	endfunction

	// row inside the bank, the bits left over after the bank index
	function automatic logic [SPM_ROW_W-1:0] spm_row_of(
		input logic [SPM_A_W-1:0] addr,
		input spm_pattern_e       pattern
	);
		logic [SPM_ROW_W-1:0] row;
		if (pattern == PAT_BLOCKED) begin
			row = addr[SPM_ROW_W-1:0];
		end else begin
			row = addr[SPM_A_W-1 -: SPM_ROW_W];
		end
		return row;
	endfunction

endpackage
